//--- sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
expand_if.sv
decode_if.sv
rvc_expander.sv
instr_decoder.sv
issue_register.sv
id_stage.sv
tb_id_stage.sv

//--- Makefile
TOP := tb_id_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- id_cases.txt
# name fetch_word pc ack_delay flush op rd rs1 rs2 imm illegal compressed ctrl_flow
# op is 0 ALU, 1 BRANCH, 2 JUMP, 3 LOAD, 4 STORE; word, pc and imm in hex, the rest decimal
add        002081b3 00001000 0 0 0 3 1 2 00000000 0 0 0
sub        407302b3 00001004 2 0 0 5 6 7 00000000 0 0 0
addi_neg   ffb58513 00001008 0 0 0 10 11 0 fffffffb 0 0 0
lw         01012403 0000100c 1 0 3 8 2 0 00000010 0 0 0
sw_neg     fe91ac23 00001010 0 1 4 0 3 9 fffffff8 0 0 0
beq_back   fe2088e3 00001014 3 0 1 0 1 2 fffffff0 0 0 1
bne_fwd    00021463 00001018 0 0 1 0 4 0 00000008 0 0 1
lui        123453b7 0000101c 0 0 0 7 0 0 12345000 0 0 0
auipc      fffff097 00001020 1 1 0 1 0 0 fffff000 0 0 0
jal        001000ef 00001024 0 0 2 1 0 0 00000800 0 0 1
jalr       00408067 00001028 2 0 2 0 1 0 00000004 0 0 1
srai       40225193 0000102c 0 0 0 3 4 0 00000402 0 0 0
bad_opcode 0000007f 00001030 0 0 0 0 0 0 00000000 1 0 0
bad_mul    02208133 00001034 1 0 0 0 0 0 00000000 1 0 0
c_nop      abcd0001 00002000 0 0 0 0 0 0 00000000 0 1 0
c_addi     0000147d 00002002 0 0 0 8 8 0 ffffffff 0 1 0
c_li       0000429d 00002004 4 0 0 5 0 0 00000007 0 1 0
c_lui      00006185 00002006 0 0 0 3 0 0 00001000 0 1 0
c_lui_neg  0000727d 00002008 0 1 0 4 0 0 fffff000 0 1 0
c_mv       0000852e 0000200a 0 0 0 10 0 11 00000000 0 1 0
c_add      00009636 0000200c 1 0 0 12 12 13 00000000 0 1 0
c_j        0000a011 0000200e 0 0 2 0 0 0 00000004 0 1 1
c_jr       00008082 00002010 0 0 2 0 1 0 00000000 0 1 1
c_jalr     00009282 00002012 2 1 2 1 5 0 00000000 0 1 1
c_beqz     0000c019 00002014 0 0 1 0 8 0 00000006 0 1 1
c_bnez     0000fcfd 00002016 0 0 1 0 9 0 fffffffe 0 1 1
c_lw       000040c8 00002018 3 0 3 10 9 0 00000004 0 1 0
c_sw       0000c60c 0000201a 0 0 4 0 12 11 00000008 0 1 0
c_zero     00000000 0000201c 0 0 0 0 0 0 00000000 1 1 0
c_addi16sp 00006105 0000201e 0 0 0 0 0 0 00000000 1 1 0
c_lwsp     00004082 00002020 1 0 0 0 0 0 00000000 1 1 0
c_ebreak   00009002 00002022 0 0 0 0 0 0 00000000 1 1 0

//--- tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int max_cases = 64;

  logic      clk_i;
  logic      rst_ni;
  logic      flush_i;
  instr_t    fetch_instr_i;
  pc_t       fetch_pc_i;
  logic      fetch_valid_i;
  logic      fetch_ready_o;
  logic      issue_ack_i;
  logic      issue_valid_o;
  op_class_e issue_op_o;
  reg_addr_t issue_rd_o;
  reg_addr_t issue_rs1_o;
  reg_addr_t issue_rs2_o;
  imm_t      issue_imm_o;
  pc_t       issue_pc_o;
  instr_t    orig_instr_o;
  logic      issue_illegal_o;
  logic      issue_compressed_o;
  logic      is_ctrl_flow_o;

  // Case table filled from id_cases.txt
  string     case_name [max_cases];
  instr_t    case_word [max_cases];
  pc_t       case_pc [max_cases];
  int        case_delay [max_cases];
  logic      case_flush [max_cases];
  op_class_e case_op [max_cases];
  reg_addr_t case_rd [max_cases];
  reg_addr_t case_rs1 [max_cases];
  reg_addr_t case_rs2 [max_cases];
  imm_t      case_imm [max_cases];
  logic      case_illegal [max_cases];
  logic      case_comp [max_cases];
  logic      case_ctrl [max_cases];

  int          num_cases = 0;
  int          max_delay = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  string       cur_name = "reset";

  id_stage UUT (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_ready_o      (fetch_ready_o),
    .issue_ack_i        (issue_ack_i),
    .issue_valid_o      (issue_valid_o),
    .issue_op_o         (issue_op_o),
    .issue_rd_o         (issue_rd_o),
    .issue_rs1_o        (issue_rs1_o),
    .issue_rs2_o        (issue_rs2_o),
    .issue_imm_o        (issue_imm_o),
    .issue_pc_o         (issue_pc_o),
    .orig_instr_o       (orig_instr_o),
    .issue_illegal_o    (issue_illegal_o),
    .issue_compressed_o (issue_compressed_o),
    .is_ctrl_flow_o     (is_ctrl_flow_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Guard against a stalled handshake
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      stop_with_error($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // --------------------
  // Typed comparisons
  // --------------------
  task automatic op_equal(input string field, input op_class_e exp_v, input op_class_e act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  task automatic reg_equal(input string field, input reg_addr_t exp_v, input reg_addr_t act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected x%0d, actual x%0d",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  task automatic imm_equal(input string field, input imm_t exp_v, input imm_t act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  task automatic pc_equal(input string field, input pc_t exp_v, input pc_t act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  task automatic instr_equal(input string field, input instr_t exp_v, input instr_t act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  task automatic bit_equal(input string field, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      stop_with_error($sformatf("MISMATCH %s %s: expected %b, actual %b",
                                cur_name, field, exp_v, act_v));
    end
  endtask

  // --------------------
  // Case file and checks
  // --------------------
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] word_v;
    logic [31:0] pc_v;
    logic [31:0] imm_v;
    int          delay;
    int          flush;
    int          op;
    int          rd;
    int          rs1;
    int          rs2;
    int          ill;
    int          comp;
    int          ctrl;
    fd = $fopen("id_cases.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open the case file id_cases.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip column notes and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %d %d %d %d %d %d %h %d %d %d", name, word_v, pc_v,
                  delay, flush, op, rd, rs1, rs2, imm_v, ill, comp, ctrl);
      if (n != 13) begin
        stop_with_error($sformatf("Case file line could not be parsed: %s", line));
      end
      if (num_cases == max_cases) begin
        stop_with_error("Case file holds more cases than the table can take");
      end
      case_name[num_cases]    = name;
      case_word[num_cases]    = word_v;
      case_pc[num_cases]      = pc_v;
      case_delay[num_cases]   = delay;
      case_flush[num_cases]   = (flush != 0);
      case_op[num_cases]      = op_class_e'(op[2:0]);
      case_rd[num_cases]      = reg_addr_t'(rd);
      case_rs1[num_cases]     = reg_addr_t'(rs1);
      case_rs2[num_cases]     = reg_addr_t'(rs2);
      case_imm[num_cases]     = imm_v;
      case_illegal[num_cases] = (ill != 0);
      case_comp[num_cases]    = (comp != 0);
      case_ctrl[num_cases]    = (ctrl != 0);
      if (delay > max_delay) begin
        max_delay = delay;
      end
      num_cases++;
    end
    $fclose(fd);
    if (num_cases == 0) begin
      stop_with_error("Case file holds no cases");
    end
  endtask

  task automatic verify_entry(input int i);
    bit_equal("issue_valid_o", 1'b1, issue_valid_o);
    op_equal("issue_op_o", case_op[i], issue_op_o);
    reg_equal("issue_rd_o", case_rd[i], issue_rd_o);
    reg_equal("issue_rs1_o", case_rs1[i], issue_rs1_o);
    reg_equal("issue_rs2_o", case_rs2[i], issue_rs2_o);
    imm_equal("issue_imm_o", case_imm[i], issue_imm_o);
    pc_equal("issue_pc_o", case_pc[i], issue_pc_o);
    instr_equal("orig_instr_o", case_word[i], orig_instr_o);
    bit_equal("issue_illegal_o", case_illegal[i], issue_illegal_o);
    bit_equal("issue_compressed_o", case_comp[i], issue_compressed_o);
    bit_equal("is_ctrl_flow_o", case_ctrl[i], is_ctrl_flow_o);
  endtask

  // Outputs right after reset
  task automatic verify_idle();
    bit_equal("issue_valid_o", 1'b0, issue_valid_o);
    op_equal("issue_op_o", OP_ALU, issue_op_o);
    reg_equal("issue_rd_o", '0, issue_rd_o);
    reg_equal("issue_rs1_o", '0, issue_rs1_o);
    reg_equal("issue_rs2_o", '0, issue_rs2_o);
    imm_equal("issue_imm_o", '0, issue_imm_o);
    pc_equal("issue_pc_o", '0, issue_pc_o);
    instr_equal("orig_instr_o", '0, orig_instr_o);
    bit_equal("issue_illegal_o", 1'b0, issue_illegal_o);
    bit_equal("issue_compressed_o", 1'b0, issue_compressed_o);
    bit_equal("is_ctrl_flow_o", 1'b0, is_ctrl_flow_o);
  endtask

  task automatic apply_case(input int i);
    int gap;
    int probe;
    int k;
    cur_name = case_name[i];
    // The next case's word is offered while this entry is still held
    probe = (i + 1 < num_cases) ? i + 1 : i;
    gap = int'($urandom % 3);
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    fetch_instr_i <= case_word[i];
    fetch_pc_i    <= case_pc[i];
    fetch_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!fetch_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    @(negedge clk_i);
    verify_entry(i);
    // Back-pressure while the ack is withheld
    for (k = 0; k < case_delay[i]; k++) begin
      @(posedge clk_i);
      fetch_instr_i <= case_word[probe];
      fetch_pc_i    <= case_pc[probe];
      fetch_valid_i <= 1'b1;
      @(negedge clk_i);
      bit_equal("fetch_ready_o while held", 1'b0, fetch_ready_o);
      verify_entry(i);
    end
    @(posedge clk_i);
    if (case_flush[i]) begin
      flush_i       <= 1'b1;
      fetch_instr_i <= case_word[probe];
      fetch_pc_i    <= case_pc[probe];
      fetch_valid_i <= 1'b1;
    end else begin
      issue_ack_i   <= 1'b1;
      fetch_valid_i <= 1'b0;
    end
    @(negedge clk_i);
    bit_equal("fetch_ready_o on release", 1'b0, fetch_ready_o);
    verify_entry(i);
    @(posedge clk_i);
    flush_i       <= 1'b0;
    issue_ack_i   <= 1'b0;
    fetch_valid_i <= 1'b0;
    @(negedge clk_i);
    bit_equal("issue_valid_o after release", 1'b0, issue_valid_o);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_ack_i   = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    void'($urandom(32'h29a2_578c));
    load_cases();
    cycle_limit = num_cases * (max_delay + 6) + 20;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    verify_idle();
    for (int i = 0; i < num_cases; i++) begin
      apply_case(i);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  // Fetch side
  input  isa_pkg::instr_t     fetch_instr_i,
  input  pipe_pkg::pc_t       fetch_pc_i,
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  // Issue side
  input  logic                issue_ack_i,
  output logic                issue_valid_o,
  output pipe_pkg::op_class_e issue_op_o,
  output pipe_pkg::reg_addr_t issue_rd_o,
  output pipe_pkg::reg_addr_t issue_rs1_o,
  output pipe_pkg::reg_addr_t issue_rs2_o,
  output pipe_pkg::imm_t      issue_imm_o,
  output pipe_pkg::pc_t       issue_pc_o,
  output isa_pkg::instr_t     orig_instr_o,
  output logic                issue_illegal_o,
  output logic                issue_compressed_o,
  output logic                is_ctrl_flow_o
);

  expand_if exp_bus ();
  decode_if dec_bus ();

  rvc_expander i_rvc_expander (
    .fetch_instr_i (fetch_instr_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_valid_i (fetch_valid_i),
    .exp           (exp_bus.source)
  );

  instr_decoder i_instr_decoder (
    .exp (exp_bus.sink),
    .dec (dec_bus.source)
  );

  issue_register i_issue_register (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .issue_ack_i        (issue_ack_i),
    .dec                (dec_bus.sink),
    .issue_valid_o      (issue_valid_o),
    .issue_op_o         (issue_op_o),
    .issue_rd_o         (issue_rd_o),
    .issue_rs1_o        (issue_rs1_o),
    .issue_rs2_o        (issue_rs2_o),
    .issue_imm_o        (issue_imm_o),
    .issue_pc_o         (issue_pc_o),
    .orig_instr_o       (orig_instr_o),
    .issue_illegal_o    (issue_illegal_o),
    .issue_compressed_o (issue_compressed_o),
    .is_ctrl_flow_o     (is_ctrl_flow_o)
  );

  // Fetch is taken only when the register has room
  assign fetch_ready_o = dec_bus.ready;

endmodule

//--- issue_register.sv
`timescale 1ns/10ps

module issue_register (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                issue_ack_i,
  decode_if.sink              dec,
  output logic                issue_valid_o,
  output pipe_pkg::op_class_e issue_op_o,
  output pipe_pkg::reg_addr_t issue_rd_o,
  output pipe_pkg::reg_addr_t issue_rs1_o,
  output pipe_pkg::reg_addr_t issue_rs2_o,
  output pipe_pkg::imm_t      issue_imm_o,
  output pipe_pkg::pc_t       issue_pc_o,
  output isa_pkg::instr_t     orig_instr_o,
  output logic                issue_illegal_o,
  output logic                issue_compressed_o,
  output logic                is_ctrl_flow_o
);
  import pipe_pkg::*;

  logic valid_q;
  logic load;

  // Space at the next edge: empty now, or the held entry leaves this cycle
  assign dec.ready = dec.valid && !flush_i && (!valid_q || issue_ack_i);
  assign load      = dec.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // --------------------
  // Entry payload
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_op_o         <= OP_ALU;
      issue_rd_o         <= '0;
      issue_rs1_o        <= '0;
      issue_rs2_o        <= '0;
      issue_imm_o        <= '0;
      issue_pc_o         <= '0;
      orig_instr_o       <= '0;
      issue_illegal_o    <= 1'b0;
      issue_compressed_o <= 1'b0;
      is_ctrl_flow_o     <= 1'b0;
    end else if (load) begin
      issue_op_o         <= dec.op;
      issue_rd_o         <= dec.rd;
      issue_rs1_o        <= dec.rs1;
      issue_rs2_o        <= dec.rs2;
      issue_imm_o        <= dec.imm;
      issue_pc_o         <= dec.pc;
      orig_instr_o       <= dec.raw;
      issue_illegal_o    <= dec.illegal;
      issue_compressed_o <= dec.compressed;
      is_ctrl_flow_o     <= dec.ctrl_flow;
    end
  end

  assign issue_valid_o = valid_q;

endmodule

//--- instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  expand_if.sink   exp,
  decode_if.source dec
);
  import isa_pkg::*;
  import pipe_pkg::*;

  instr_t    instr;
  opcode_e   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  op_class_e op_d;
  reg_addr_t rd_d, rs1_d, rs2_d;
  imm_t      imm_d;
  logic      ctrl_d;
  logic      bad_d;
  logic      illegal;

  assign instr  = exp.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // --------------------
  // Immediate formats
  // --------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op_d   = OP_ALU;
    rd_d   = '0;
    rs1_d  = '0;
    rs2_d  = '0;
    imm_d  = '0;
    ctrl_d = 1'b0;
    bad_d  = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        rd_d  = instr[11:7];
        imm_d = imm_u;
      end
      OPC_JAL: begin
        op_d   = OP_JUMP;
        rd_d   = instr[11:7];
        imm_d  = imm_j;
        ctrl_d = 1'b1;
      end
      OPC_JALR: begin
        op_d   = OP_JUMP;
        rd_d   = instr[11:7];
        rs1_d  = instr[19:15];
        imm_d  = imm_i;
        ctrl_d = 1'b1;
        bad_d  = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        op_d   = OP_BRANCH;
        rs1_d  = instr[19:15];
        rs2_d  = instr[24:20];
        imm_d  = imm_b;
        ctrl_d = 1'b1;
        // funct3 010 and 011 are unused
        bad_d  = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        op_d  = OP_LOAD;
        rd_d  = instr[11:7];
        rs1_d = instr[19:15];
        imm_d = imm_i;
        bad_d = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        op_d  = OP_STORE;
        rs1_d = instr[19:15];
        rs2_d = instr[24:20];
        imm_d = imm_s;
        bad_d = (funct3[2] || funct3 == 3'b011);
      end
      OPC_OP_IMM: begin
        rd_d  = instr[11:7];
        rs1_d = instr[19:15];
        imm_d = imm_i;
        // Shift amounts leave funct7 for the shift type
        if (funct3 == 3'b001) begin
          bad_d = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          bad_d = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_OP: begin
        rd_d  = instr[11:7];
        rs1_d = instr[19:15];
        rs2_d = instr[24:20];
        if (funct7 == 7'b0100000) begin
          bad_d = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          bad_d = (funct7 != 7'b0000000);
        end
      end
      default: bad_d = 1'b1;
    endcase
  end

  assign illegal = exp.illegal | bad_d;

  // Illegal entries keep only pc, raw word and compressed flag
  assign dec.valid      = exp.valid;
  assign dec.op         = illegal ? OP_ALU : op_d;
  assign dec.rd         = illegal ? '0 : rd_d;
  assign dec.rs1        = illegal ? '0 : rs1_d;
  assign dec.rs2        = illegal ? '0 : rs2_d;
  assign dec.imm        = illegal ? '0 : imm_d;
  assign dec.ctrl_flow  = illegal ? 1'b0 : ctrl_d;
  assign dec.illegal    = illegal;
  assign dec.pc         = exp.pc;
  assign dec.raw        = exp.raw;
  assign dec.compressed = exp.compressed;

endmodule

//--- rvc_expander.sv
`timescale 1ns/10ps
`include "id_defines.svh"

module rvc_expander (
  input  isa_pkg::instr_t fetch_instr_i,
  input  pipe_pkg::pc_t   fetch_pc_i,
  input  logic            fetch_valid_i,
  expand_if.source        exp
);
  import isa_pkg::*;
  import pipe_pkg::*;

  cinstr_t   cinstr;
  cquad_e    quad;
  reg_addr_t c_rd;
  reg_addr_t c_rs2;
  instr_t    exp_instr;
  logic      exp_illegal;

  // Prime registers x8 to x15 from a 3-bit field
  function automatic reg_addr_t creg(input logic [2:0] r);
    creg = {2'b01, r};
  endfunction

  assign cinstr = fetch_instr_i[`ID_CLEN-1:0];
  assign quad   = cquad_e'(fetch_instr_i[1:0]);
  assign c_rd   = cinstr[11:7];
  assign c_rs2  = cinstr[6:2];

  always_comb begin
    exp_instr   = '0;
    exp_illegal = 1'b0;
    case (quad)
      // --------------------
      // Quadrant 0
      // --------------------
      Q_C0: begin
        case (cinstr[15:13])
          // C.LW -> lw rd', uimm(rs1')
          3'b010: exp_instr = {5'b0, cinstr[5], cinstr[12:10], cinstr[6], 2'b00,
                               creg(cinstr[9:7]), 3'b010, creg(cinstr[4:2]), OPC_LOAD};
          // C.SW -> sw rs2', uimm(rs1')
          3'b110: exp_instr = {5'b0, cinstr[5], cinstr[12], creg(cinstr[4:2]),
                               creg(cinstr[9:7]), 3'b010, cinstr[11:10], cinstr[6], 2'b00,
                               OPC_STORE};
          // All-zero word lands here too
          default: exp_illegal = 1'b1;
        endcase
      end
      // --------------------
      // Quadrant 1
      // --------------------
      Q_C1: begin
        case (cinstr[15:13])
          // C.ADDI, C.NOP when rd is x0
          3'b000: exp_instr = {{7{cinstr[12]}}, cinstr[6:2], c_rd, 3'b000, c_rd, OPC_OP_IMM};
          // C.LI -> addi rd, x0, imm
          3'b010: exp_instr = {{7{cinstr[12]}}, cinstr[6:2], 5'b0, 3'b000, c_rd, OPC_OP_IMM};
          3'b011: begin
            // rd of x2 is C.ADDI16SP, not in the subset
            if (c_rd == 5'd2 || {cinstr[12], cinstr[6:2]} == 6'b0) begin
              exp_illegal = 1'b1;
            end else begin
              exp_instr = {{15{cinstr[12]}}, cinstr[6:2], c_rd, OPC_LUI};
            end
          end
          // C.J -> jal x0, offset
          3'b101: exp_instr = {cinstr[12], cinstr[8], cinstr[10:9], cinstr[6], cinstr[7],
                               cinstr[2], cinstr[11], cinstr[5:3], cinstr[12],
                               {8{cinstr[12]}}, 5'b0, OPC_JAL};
          // C.BEQZ and C.BNEZ differ only in funct3 bit 0
          3'b110, 3'b111: exp_instr = {cinstr[12], {3{cinstr[12]}}, cinstr[6:5], cinstr[2],
                                       5'b0, creg(cinstr[9:7]), 2'b00, cinstr[13],
                                       cinstr[11:10], cinstr[4:3], cinstr[12], OPC_BRANCH};
          default: exp_illegal = 1'b1;
        endcase
      end
      // --------------------
      // Quadrant 2
      // --------------------
      Q_C2: begin
        if (cinstr[15:13] != 3'b100) begin
          exp_illegal = 1'b1;
        end else if (!cinstr[12]) begin
          if (c_rs2 != 5'd0) begin
            // C.MV -> add rd, x0, rs2
            exp_instr = {7'b0, c_rs2, 5'b0, 3'b000, c_rd, OPC_OP};
          end else if (c_rd != 5'd0) begin
            // C.JR -> jalr x0, 0(rs1)
            exp_instr = {12'b0, c_rd, 3'b000, 5'b0, OPC_JALR};
          end else begin
            exp_illegal = 1'b1;
          end
        end else begin
          if (c_rs2 != 5'd0) begin
            // C.ADD -> add rd, rd, rs2
            exp_instr = {7'b0, c_rs2, c_rd, 3'b000, c_rd, OPC_OP};
          end else if (c_rd != 5'd0) begin
            // C.JALR links to x1
            exp_instr = {12'b0, c_rd, 3'b000, 5'd1, OPC_JALR};
          end else begin
            // C.EBREAK
            exp_illegal = 1'b1;
          end
        end
      end
      Q_NONE: exp_instr = fetch_instr_i;
      default: exp_illegal = 1'b1;
    endcase
  end

  assign exp.valid      = fetch_valid_i;
  assign exp.instr      = exp_instr;
  assign exp.raw        = fetch_instr_i;
  assign exp.pc         = fetch_pc_i;
  assign exp.compressed = (quad != Q_NONE);
  assign exp.illegal    = exp_illegal;

endmodule

//--- decode_if.sv
`timescale 1ns/10ps

interface decode_if;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic      valid;
  logic      ready;
  op_class_e op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  imm_t      imm;
  pc_t       pc;
  instr_t    raw;
  logic      compressed;
  logic      illegal;
  logic      ctrl_flow;

  // Decoder side, ready comes back from the register
  modport source (output valid, op, rd, rs1, rs2, imm, pc, raw, compressed, illegal, ctrl_flow,
                  input  ready);

  modport sink   (input  valid, op, rd, rs1, rs2, imm, pc, raw, compressed, illegal, ctrl_flow,
                  output ready);

endinterface

//--- expand_if.sv
`timescale 1ns/10ps

interface expand_if;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic   valid;
  instr_t instr;
  instr_t raw;
  pc_t    pc;
  logic   compressed;
  logic   illegal;

  modport source (output valid, instr, raw, pc, compressed, illegal);
  modport sink   (input  valid, instr, raw, pc, compressed, illegal);

endinterface

//--- pipe_pkg.sv
`include "id_defines.svh"

package pipe_pkg;

  // --------------------
  // Issue entry types
  // --------------------

  // Operation class seen by the issue stage
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_BRANCH = 3'd1,
    OP_JUMP   = 3'd2,
    OP_LOAD   = 3'd3,
    OP_STORE  = 3'd4
  } op_class_e;

  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // Immediate, always sign-extended to full width
  typedef logic [`ID_XLEN-1:0] imm_t;

  typedef logic [`ID_XLEN-1:0] pc_t;

endpackage

//--- isa_pkg.sv
`include "id_defines.svh"

package isa_pkg;

  // --------------------
  // Instruction words
  // --------------------

  typedef logic [`ID_ILEN-1:0] instr_t;
  typedef logic [`ID_CLEN-1:0] cinstr_t;

  // --------------------
  // Encodings
  // --------------------

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // Low two bits of a fetch word
  // 11 marks a full 32-bit instruction
  typedef enum logic [1:0] {
    Q_C0   = 2'b00,
    Q_C1   = 2'b01,
    Q_C2   = 2'b10,
    Q_NONE = 2'b11
  } cquad_e;

endpackage

//--- id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// --------------------
// Fixed ISA widths
// --------------------

// Full instruction word
`define ID_ILEN 32

// Compressed instruction word
`define ID_CLEN 16

// PC and immediate width
`define ID_XLEN 32

// Register address width, 32 integer registers
`define ID_REG_AW 5

`endif
